// File: source/spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// command word shifted out per frame
`define SPI_CMD_WIDTH 12
// bits clocked in on a read
`define SPI_READ_WIDTH 8
// system clocks per sclk half period, 2 or more
`define SPI_CLK_DIV 4
`define WB_DATA_WIDTH 16

`endif

// File: source/wb_bus_pkg.sv
`include "spi_settings.svh"

package wb_bus_pkg;

  typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;

  // address 3 is unmapped and reads as zero
  typedef enum logic [1:0] {
    REG_CMD    = 2'd0,
    REG_STATUS = 2'd1,
    REG_RDATA  = 2'd2
  } wb_reg_e;

  // status word layout
  localparam int STATUS_BUSY_BIT   = 0;
  localparam int STATUS_RVALID_BIT = 1;

endpackage

// File: source/spi_frame_pkg.sv
`include "spi_settings.svh"

package spi_frame_pkg;

  localparam int ADDR_W   = `SPI_CMD_WIDTH - `SPI_READ_WIDTH - 1;
  // flag plus address, the only bits sent on a read
  localparam int HDR_BITS = 1 + ADDR_W;
  localparam int CNT_W    = $clog2(`SPI_CMD_WIDTH + 1);

  typedef struct packed {
    logic                       wr_flag;
    logic [ADDR_W-1:0]          addr;
    logic [`SPI_READ_WIDTH-1:0] data;
  } spi_wr_cmd_t;

  typedef struct packed {
    logic                       wr_flag;
    logic [ADDR_W-1:0]          addr;
    logic [`SPI_READ_WIDTH-1:0] unused;
  } spi_rd_cmd_t;

  typedef union packed {
    spi_wr_cmd_t wr;
    spi_rd_cmd_t rd;
  } spi_cmd_u;

  // tx is left aligned, MSB goes out first
  typedef struct packed {
    logic [`SPI_CMD_WIDTH-1:0] tx;
    logic [CNT_W-1:0]          tx_bits;
    logic [CNT_W-1:0]          rx_bits;
  } spi_frame_t;

endpackage

// File: source/spi_ifs.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

interface cmd_if;
  import spi_frame_pkg::*;

  spi_cmd_u                   cmd;
  logic                       vld;
  logic                       rdy;
  logic [`SPI_READ_WIDTH-1:0] rdata;
  logic                       rdata_vld;

  modport controller (
    output cmd,
    output vld,
    input  rdy,
    input  rdata,
    input  rdata_vld
  );

  modport target (
    input  cmd,
    input  vld,
    output rdy,
    output rdata,
    output rdata_vld
  );
endinterface

interface shift_if;
  import spi_frame_pkg::*;

  spi_frame_t                 frame;
  logic                       start;
  logic                       busy;
  logic [`SPI_READ_WIDTH-1:0] rx;
  logic                       done;

  modport controller (output frame, output start, input busy, input rx, input done);
  modport target (input frame, input start, output busy, output rx, output done);
endinterface

// File: source/wb_spi_regs.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module wb_spi_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  wb_bus_pkg::wb_reg_e  wb_adr,
  input  wb_bus_pkg::wb_data_t wb_dat_w,
  output wb_bus_pkg::wb_data_t wb_dat_r,
  output logic                 wb_ack,
  cmd_if.controller            cmd_bus
);
  import wb_bus_pkg::*;

  logic                       req;
  logic                       cmd_write;
  logic                       rdata_valid;
  logic [`SPI_READ_WIDTH-1:0] rdata;
  wb_data_t                   rd_word;

  // a cycle is new until its ack has been given
  assign req       = wb_cyc && wb_stb && !wb_ack;
  assign cmd_write = req && wb_we && (wb_adr == REG_CMD);

  // command stays valid as long as the master holds the write
  assign cmd_bus.vld = cmd_write;
  assign cmd_bus.cmd = wb_dat_w[`SPI_CMD_WIDTH-1:0];

  always_comb
  begin
    rd_word = '0;
    case (wb_adr)
      REG_STATUS:
      begin
        rd_word[STATUS_BUSY_BIT]   = !cmd_bus.rdy;
        rd_word[STATUS_RVALID_BIT] = rdata_valid;
      end
      REG_RDATA: rd_word[`SPI_READ_WIDTH-1:0] = rdata;
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack      <= 1'b0;
      rdata_valid <= 1'b0;
    end
    else
    begin
      // cmd writes wait for the sequencer to take the command
      wb_ack <= cmd_write ? cmd_bus.rdy : req;
      if (cmd_bus.rdata_vld)
        rdata_valid <= 1'b1;
      else if (req && !wb_we && (wb_adr == REG_RDATA))
        rdata_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_bus.rdata_vld)
      rdata <= cmd_bus.rdata;
    if (req && !wb_we)
      wb_dat_r <= rd_word;
  end

endmodule

// File: source/spi_sequencer.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_sequencer (
  input  logic         clk,
  input  logic         rst_n,
  cmd_if.target        cmd_bus,
  shift_if.controller  shift_bus
);
  import spi_frame_pkg::*;

  logic       active;
  logic       is_read;
  logic       accept;
  spi_frame_t next_frame;

  assign cmd_bus.rdy = !active;
  assign accept      = cmd_bus.vld && cmd_bus.rdy;

  // same word seen as a write or as a read header
  always_comb
  begin
    if (cmd_bus.cmd.wr.wr_flag)
    begin
      next_frame.tx      = {cmd_bus.cmd.wr.wr_flag, cmd_bus.cmd.wr.addr, cmd_bus.cmd.wr.data};
      next_frame.tx_bits = CNT_W'(`SPI_CMD_WIDTH);
      next_frame.rx_bits = '0;
    end
    else
    begin
      next_frame.tx      = {cmd_bus.cmd.rd.wr_flag, cmd_bus.cmd.rd.addr,
                            {`SPI_READ_WIDTH{1'b0}}};
      next_frame.tx_bits = CNT_W'(HDR_BITS);
      next_frame.rx_bits = CNT_W'(`SPI_READ_WIDTH);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active            <= 1'b0;
      is_read           <= 1'b0;
      shift_bus.start   <= 1'b0;
      cmd_bus.rdata_vld <= 1'b0;
    end
    else
    begin
      shift_bus.start   <= accept;
      cmd_bus.rdata_vld <= 1'b0;
      if (accept)
      begin
        active  <= 1'b1;
        is_read <= !cmd_bus.cmd.wr.wr_flag;
      end
      else if (shift_bus.done)
      begin
        active            <= 1'b0;
        cmd_bus.rdata_vld <= is_read;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      shift_bus.frame <= next_frame;
    if (shift_bus.done)
      cmd_bus.rdata <= shift_bus.rx;
  end

endmodule

// File: source/spi_shifter.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_shifter (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    miso,
  shift_if.target shift_bus,
  output logic    sclk,
  output logic    cs_n,
  output logic    mosi
);
  import spi_frame_pkg::*;

  localparam int DIV_W = $clog2(`SPI_CLK_DIV);
  localparam int MSB   = `SPI_CMD_WIDTH - 1;

  logic [DIV_W-1:0]           div_cnt;
  logic [CNT_W-1:0]           bit_cnt;
  logic [CNT_W-1:0]           next_cnt;
  logic [CNT_W-1:0]           tx_bits;
  logic [CNT_W-1:0]           total_bits;
  logic [`SPI_CMD_WIDTH-1:0]  tx_sh;
  logic [`SPI_READ_WIDTH-1:0] rx_sh;
  logic                       load;
  logic                       half_done;

  assign load      = shift_bus.start && !shift_bus.busy;
  assign half_done = shift_bus.busy && (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
  assign next_cnt  = bit_cnt + 1'b1;
  assign shift_bus.rx = rx_sh;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_bus.busy <= 1'b0;
      shift_bus.done <= 1'b0;
      cs_n           <= 1'b1;
      sclk           <= 1'b0;
      mosi           <= 1'b0;
      div_cnt        <= '0;
      bit_cnt        <= '0;
    end
    else
    begin
      shift_bus.done <= 1'b0;
      if (load)
      begin
        shift_bus.busy <= 1'b1;
        cs_n           <= 1'b0;
        // first bit is on the line before the first rising edge
        mosi           <= shift_bus.frame.tx[MSB];
        div_cnt        <= '0;
        bit_cnt        <= '0;
      end
      else if (half_done)
      begin
        div_cnt <= '0;
        sclk    <= !sclk;
        // falling edge closes a bit
        if (sclk)
        begin
          if (next_cnt == total_bits)
          begin
            shift_bus.busy <= 1'b0;
            shift_bus.done <= 1'b1;
            cs_n           <= 1'b1;
            mosi           <= 1'b0;
          end
          else
          begin
            bit_cnt <= next_cnt;
            mosi    <= (next_cnt < tx_bits) ? tx_sh[MSB-1] : 1'b0;
          end
        end
      end
      else if (shift_bus.busy)
        div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      tx_sh      <= shift_bus.frame.tx;
      tx_bits    <= shift_bus.frame.tx_bits;
      total_bits <= shift_bus.frame.tx_bits + shift_bus.frame.rx_bits;
    end
    else if (half_done)
    begin
      if (sclk)
        tx_sh <= tx_sh << 1;
      // rising edge, sample once the header is out
      else if (bit_cnt >= tx_bits)
        rx_sh <= {rx_sh[`SPI_READ_WIDTH-2:0], miso};
    end
  end

endmodule

// File: source/wb_spi_master.sv
`timescale 1ns/1ps

module wb_spi_master (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  wb_bus_pkg::wb_reg_e  wb_adr,
  input  wb_bus_pkg::wb_data_t wb_dat_w,
  input  logic                 miso,
  output wb_bus_pkg::wb_data_t wb_dat_r,
  output logic                 wb_ack,
  output logic                 sclk,
  output logic                 cs_n,
  output logic                 mosi
);

  cmd_if   cmd_bus ();
  shift_if shift_bus ();

  // register front end, then frame decode, then the line itself
  wb_spi_regs regs0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .cmd_bus  (cmd_bus.controller)
  );

  spi_sequencer seq0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_bus   (cmd_bus.target),
    .shift_bus (shift_bus.controller)
  );

  spi_shifter shift0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .miso      (miso),
    .shift_bus (shift_bus.target),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi)
  );

endmodule

// File: verification/wb_spi_chk.sv
`timescale 1ns/1ps

module wb_spi_chk (
  input logic clk,
  input logic rst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic sclk,
  input logic cs_n,
  input logic mosi
);

  // ack only answers a cycle that is still requested
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack seen without wb_cyc and wb_stb");

  a_single_ack: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held for two clocks");

  // mode 0 idles low
  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cs_n |-> !sclk)
    else $error("sclk high while cs_n is high");

  // covers the rising edge itself as well as the high phase
  a_mosi_stable: assert property (@(posedge clk) disable iff (!rst_n)
    sclk |-> $stable(mosi))
    else $error("mosi changed while sclk is high");

endmodule

bind wb_spi_master wb_spi_chk chk0 (
  .clk    (clk),
  .rst_n  (rst_n),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .sclk   (sclk),
  .cs_n   (cs_n),
  .mosi   (mosi)
);

// File: verification/tb_wb_spi_master.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module tb_wb_spi_master;
  import wb_bus_pkg::*;

  localparam int NUM_STEPS  = 10;
  localparam int ACK_LIMIT  = 4 * `SPI_CLK_DIV * `SPI_CMD_WIDTH;
  localparam int POLL_LIMIT = 2 * `SPI_CLK_DIV * `SPI_CMD_WIDTH;
  localparam int OP_REG = 0;
  localparam int OP_WR  = 1;
  localparam int OP_RD  = 2;

  logic        clk = 1'b0;
  logic        rst_n, wb_cyc, wb_stb, wb_we, wb_ack, sclk, cs_n, mosi;
  logic        miso = 1'b0;
  wb_reg_e     wb_adr;
  wb_data_t    wb_dat_w, wb_dat_r, rd_val;
  logic        cs_n_at_ack;
  int          frames_done = 0;
  int          frames_at_ack, errors = 0, checks = 0;
  logic [31:0] lfsr = 32'he8ad_6892;
  logic [7:0]  slave_mem [8];
  logic [7:0]  exp_mem [8];
  logic [11:0] slv_in;
  logic [7:0]  out_sh;
  logic [3:0]  slv_bits;
  logic        sclk_q, cs_q, rd_mode;

  // register reads use the low two address bits as the Wishbone address
  string      step_name [NUM_STEPS] = '{"status_idle", "unmapped_adr3", "rd_preset_2",
    "wr_dev5", "wr_dev0", "rd_dev5", "wr_dev7", "rd_dev0", "rd_dev7", "rd_preset_3"};
  int         step_op   [NUM_STEPS] = '{OP_REG, OP_REG, OP_RD, OP_WR, OP_WR,
    OP_RD, OP_WR, OP_RD, OP_RD, OP_RD};
  logic [2:0] step_addr [NUM_STEPS] = '{3'd1, 3'd3, 3'd2, 3'd5, 3'd0,
    3'd5, 3'd7, 3'd0, 3'd7, 3'd3};
  logic [7:0] step_val  [NUM_STEPS] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'ha5,
    8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
  bit         step_rnd  [NUM_STEPS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
    1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

  wb_spi_master dut0 (.*);

  always #10 clk = ~clk;

  function automatic logic [7:0] preset_byte(input int addr);
    return 8'((addr * 37) ^ 8'h3c);
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_byte(output logic [7:0] b);
    b = '0;
    for (int k = 0; k < 8; k++)
    begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic check(input string name, input wb_data_t exp, input wb_data_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  // one classic cycle, outputs sampled on the falling clock
  task automatic wb_access(input logic we, input wb_reg_e adr, input wb_data_t data);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= data;
    @(negedge clk);
    while (!wb_ack && waited < ACK_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!wb_ack)
    begin
      errors++;
      $display("no Wishbone ack within %0d cycles at address %0d", ACK_LIMIT, adr);
    end
    rd_val        = wb_dat_r;
    cs_n_at_ack   = cs_n;
    frames_at_ack = frames_done;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wait_status(input int bit_idx, input logic level, input string what);
    int polls;
    polls = 0;
    wb_access(1'b0, REG_STATUS, '0);
    while (rd_val[bit_idx] !== level && polls < POLL_LIMIT)
    begin
      wb_access(1'b0, REG_STATUS, '0);
      polls++;
    end
    if (rd_val[bit_idx] !== level)
    begin
      errors++;
      $display("status bit %0d never became %b during %s", bit_idx, level, what);
    end
  endtask

  task automatic run_step(input int i);
    logic [7:0] value;
    value = step_val[i];
    if (step_rnd[i])
      take_byte(value);
    case (step_op[i])
      OP_REG:
      begin
        wb_access(1'b0, wb_reg_e'(step_addr[i][1:0]), '0);
        check(step_name[i], 16'(value), rd_val);
      end
      OP_WR:
      begin
        wb_access(1'b1, REG_CMD, {4'h0, 1'b1, step_addr[i], value});
        wait_status(STATUS_BUSY_BIT, 1'b0, step_name[i]);
        exp_mem[step_addr[i]] = value;
        check(step_name[i], 16'(value), 16'(slave_mem[step_addr[i]]));
      end
      default:
      begin
        wb_access(1'b1, REG_CMD, {4'h0, 1'b0, step_addr[i], 8'h00});
        wait_status(STATUS_RVALID_BIT, 1'b1, step_name[i]);
        wb_access(1'b0, REG_RDATA, '0);
        check(step_name[i], 16'(exp_mem[step_addr[i]]), rd_val);
        // reading the byte drops rdata_valid
        wb_access(1'b0, REG_STATUS, '0);
        check({step_name[i], "_cleared"}, 16'h0, rd_val);
      end
    endcase
  endtask

  // SPI slave register file, mode 0, sclk edges seen one clock late
  always @(posedge clk)
  begin
    logic [11:0] shifted;
    shifted = {slv_in[10:0], mosi};
    sclk_q <= sclk;
    cs_q   <= cs_n;
    if (!rst_n)
    begin
      for (int a = 0; a < 8; a++)
        slave_mem[a] <= preset_byte(a);
      miso    <= 1'b0;
      rd_mode <= 1'b0;
    end
    else if (cs_n)
    begin
      if (!cs_q)
        frames_done <= frames_done + 1;
      slv_bits <= '0;
      rd_mode  <= 1'b0;
    end
    else if (sclk && !sclk_q)
    begin
      slv_in   <= shifted;
      slv_bits <= slv_bits + 4'd1;
      if (slv_bits == 4'd3 && !shifted[3])
      begin
        rd_mode <= 1'b1;
        out_sh  <= slave_mem[shifted[2:0]];
      end
      if (slv_bits == 4'd11 && shifted[11])
        slave_mem[shifted[10:8]] <= shifted[7:0];
    end
    else if (!sclk && sclk_q && rd_mode)
    begin
      miso   <= out_sh[7];
      out_sh <= {out_sh[6:0], 1'b0};
    end
  end

  initial
  begin
    logic [7:0] first_byte;
    int base;
    rst_n    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= REG_CMD;
    wb_dat_w <= '0;
    for (int a = 0; a < 8; a++)
      exp_mem[a] = preset_byte(a);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // ack, cs_n, sclk, mosi
    check("reset_lines", 16'h4, 16'({wb_ack, cs_n, sclk, mosi}));

    for (int i = 0; i < NUM_STEPS; i++)
      run_step(i);

    // second command waits until the first frame has ended
    base = frames_done;
    take_byte(first_byte);
    wb_access(1'b1, REG_CMD, {4'h0, 1'b1, 3'd6, first_byte});
    wb_access(1'b1, REG_CMD, {4'h0, 1'b0, 3'd6, 8'h00});
    check("b2b_ack_after_frame", 16'(base + 1), 16'(frames_at_ack));
    wb_access(1'b0, REG_STATUS, '0);
    check("busy_in_frame", 16'h1, rd_val);
    check("cs_n_in_frame", 16'h0, 16'(cs_n_at_ack));
    wait_status(STATUS_RVALID_BIT, 1'b1, "b2b read");
    wb_access(1'b0, REG_RDATA, '0);
    check("b2b_in_order", 16'(first_byte), rd_val);

    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  initial
  begin
    #1_000_000;
    $display("simulation did not reach the end within the time limit");
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+source
source/wb_bus_pkg.sv
source/spi_frame_pkg.sv
source/spi_ifs.sv
source/wb_spi_regs.sv
source/spi_sequencer.sv
source/spi_shifter.sv
source/wb_spi_master.sv
verification/wb_spi_chk.sv
verification/tb_wb_spi_master.sv

// File: Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_wb_spi_master -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
